//--- source/mips_pkg.sv
package mips_pkg;

	localparam int word_w = 32;
	localparam int reg_count = 32;
	localparam int dmem_addr_w = 8;
	localparam int dmem_words = 1 << dmem_addr_w; // 256 words
	localparam int link_reg = 31; // jal destination

	typedef logic [word_w-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// primary opcodes
	localparam opcode_t op_rtype = 6'h00;
	localparam opcode_t op_j = 6'h02;
	localparam opcode_t op_jal = 6'h03;
	localparam opcode_t op_beq = 6'h04;
	localparam opcode_t op_addiu = 6'h09;
	localparam opcode_t op_ori = 6'h0d;
	localparam opcode_t op_lui = 6'h0f;
	localparam opcode_t op_lw = 6'h23;
	localparam opcode_t op_sw = 6'h2b;

	// r-type function field
	localparam funct_t fn_jr = 6'h08;
	localparam funct_t fn_addu = 6'h21;
	localparam funct_t fn_subu = 6'h23;
	localparam funct_t fn_and = 6'h24;
	localparam funct_t fn_or = 6'h25;
	localparam funct_t fn_slt = 6'h2a;

	typedef enum logic [2:0] {
		alu_disable, alu_addu, alu_subu, alu_and, alu_or, alu_slt, alu_setu
	} alu_op_e;

	typedef enum logic {src_reg, src_imm} alu_src_e;

	typedef enum logic [1:0] {br_none, br_eqz, br_uncond} branch_op_e;

	typedef enum logic [1:0] {mem_none, mem_lw, mem_sw} mem_op_e;

	typedef enum logic [2:0] {
		st_idle, st_fetch, st_decode, st_execute, st_memory, st_writeback
	} ctrl_state_e;

	typedef struct packed {
		alu_op_e alu_op;
		alu_src_e alu_src;
		word_t reg1_data;
		word_t reg2_data;
		word_t imm;
		reg_addr_t wb_addr;
		branch_op_e branch_op;
		word_t branch_dest;
		logic jump_reg; // target taken from reg2_data
		mem_op_e mem_op;
		word_t pc;
	} id2ex_t;

	typedef struct packed {
		word_t result;
		word_t store_data;
		reg_addr_t wb_addr;
		mem_op_e mem_op;
		word_t next_pc;
	} ex2wb_t;

	typedef struct packed {
		word_t pc;
		reg_addr_t wb_addr;
		word_t wb_data;
	} retire_t;

endpackage

//--- source/register_file.sv
module register_file (
	input logic clk,
	input logic rst,
	input mips_pkg::reg_addr_t read1_addr,
	input mips_pkg::reg_addr_t read2_addr,
	input mips_pkg::reg_addr_t write_addr,
	input mips_pkg::word_t write_data,
	input logic write_en,
	output mips_pkg::word_t read1_data,
	output mips_pkg::word_t read2_data
);

	mips_pkg::word_t regs [mips_pkg::reg_count];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < mips_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_addr != '0) begin // r0 stays zero
			regs[write_addr] <= write_data;
		end
	end

	// combinational reads, old value on same-cycle write
	always_comb begin
		read1_data = (read1_addr == '0) ? '0 : regs[read1_addr];
		read2_data = (read2_addr == '0) ? '0 : regs[read2_addr];
	end

endmodule

//--- source/stage_id.sv
module stage_id (
	input logic clk,
	input logic rst,
	input logic decode_en,
	input mips_pkg::instr_t instr,
	input mips_pkg::word_t pc,
	input mips_pkg::reg_addr_t reg_write_addr,
	input mips_pkg::word_t reg_write_data,
	input logic reg_write_en,
	output mips_pkg::id2ex_t id2ex
);

	mips_pkg::opcode_t opcode;
	mips_pkg::funct_t funct;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	logic [15:0] imm16;
	mips_pkg::word_t imm_sext;
	mips_pkg::word_t imm_zext;
	mips_pkg::word_t pc_plus4;
	mips_pkg::word_t br_target;
	mips_pkg::word_t jmp_target;
	mips_pkg::word_t rs_data;
	mips_pkg::word_t rt_data;
	mips_pkg::id2ex_t dec;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm16 = instr[15:0];

	assign imm_sext = {{16{imm16[15]}}, imm16};
	assign imm_zext = {16'b0, imm16};
	assign pc_plus4 = pc + 32'd4;
	assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00}; // pc relative
	assign jmp_target = {pc_plus4[31:28], instr[25:0], 2'b00}; // 256MB region

	register_file register_file_i (
		.clk(clk),
		.rst(rst),
		.read1_addr(rs),
		.read2_addr(rt),
		.write_addr(reg_write_addr),
		.write_data(reg_write_data),
		.write_en(reg_write_en),
		.read1_data(rs_data),
		.read2_data(rt_data)
	);

	always_comb begin
		dec = '0;
		dec.pc = pc; // next pc of a no-op still needs it
		case (opcode)
			mips_pkg::op_rtype: begin
				case (funct)
					mips_pkg::fn_addu: dec.alu_op = mips_pkg::alu_addu;
					mips_pkg::fn_subu: dec.alu_op = mips_pkg::alu_subu;
					mips_pkg::fn_and: dec.alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or: dec.alu_op = mips_pkg::alu_or;
					mips_pkg::fn_slt: dec.alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_jr: begin
						dec.branch_op = mips_pkg::br_uncond;
						dec.jump_reg = 1'b1;
						dec.reg2_data = rs_data;
					end
					default: ; // unknown function, no-op
				endcase
				if (dec.alu_op != mips_pkg::alu_disable) begin
					dec.reg1_data = rs_data;
					dec.reg2_data = rt_data;
					dec.alu_src = mips_pkg::src_reg;
					dec.wb_addr = rd;
				end
			end
			mips_pkg::op_j: begin
				dec.branch_op = mips_pkg::br_uncond;
				dec.branch_dest = jmp_target;
			end
			mips_pkg::op_jal: begin
				dec.branch_op = mips_pkg::br_uncond;
				dec.branch_dest = jmp_target;
				dec.reg1_data = pc_plus4; // link value via addu with zero
				dec.alu_op = mips_pkg::alu_addu;
				dec.wb_addr = mips_pkg::reg_addr_t'(mips_pkg::link_reg);
			end
			mips_pkg::op_beq: begin
				dec.reg1_data = rs_data;
				dec.reg2_data = rt_data;
				dec.alu_op = mips_pkg::alu_subu;
				dec.branch_op = mips_pkg::br_eqz;
				dec.branch_dest = br_target;
			end
			mips_pkg::op_addiu, mips_pkg::op_ori, mips_pkg::op_lui: begin
				dec.reg1_data = rs_data;
				dec.alu_src = mips_pkg::src_imm;
				dec.wb_addr = rt;
				if (opcode == mips_pkg::op_addiu) begin
					dec.alu_op = mips_pkg::alu_addu;
					dec.imm = imm_sext;
				end else if (opcode == mips_pkg::op_ori) begin
					dec.alu_op = mips_pkg::alu_or;
					dec.imm = imm_zext;
				end else begin
					dec.alu_op = mips_pkg::alu_setu;
					dec.imm = {imm16, 16'b0};
				end
			end
			mips_pkg::op_lw, mips_pkg::op_sw: begin
				dec.reg1_data = rs_data;
				dec.reg2_data = rt_data;
				dec.alu_op = mips_pkg::alu_addu; // address = base + offset
				dec.alu_src = mips_pkg::src_imm;
				dec.imm = imm_sext;
				if (opcode == mips_pkg::op_lw) begin
					dec.mem_op = mips_pkg::mem_lw;
					dec.wb_addr = rt;
				end else begin
					dec.mem_op = mips_pkg::mem_sw;
				end
			end
			default: ; // invalid opcode leaves the bundle cleared
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			id2ex <= '0;
		end else if (decode_en) begin
			id2ex <= dec;
		end
	end

endmodule

//--- source/alu.sv
module alu (
	input logic clk,
	input logic rst,
	input logic exec_en,
	input mips_pkg::id2ex_t id2ex,
	output mips_pkg::ex2wb_t ex2wb
);

	mips_pkg::word_t op_b;
	mips_pkg::word_t result;
	mips_pkg::word_t next_pc;
	logic taken;

	assign op_b = (id2ex.alu_src == mips_pkg::src_imm) ? id2ex.imm : id2ex.reg2_data;

	always_comb begin
		case (id2ex.alu_op)
			mips_pkg::alu_addu: result = id2ex.reg1_data + op_b;
			mips_pkg::alu_subu: result = id2ex.reg1_data - op_b;
			mips_pkg::alu_and: result = id2ex.reg1_data & op_b;
			mips_pkg::alu_or: result = id2ex.reg1_data | op_b;
			mips_pkg::alu_slt: result = {31'b0, $signed(id2ex.reg1_data) < $signed(op_b)};
			mips_pkg::alu_setu: result = id2ex.imm;
			default: result = '0;
		endcase
	end

	// beq compares through the subtraction
	assign taken = (id2ex.branch_op == mips_pkg::br_uncond) ||
		(id2ex.branch_op == mips_pkg::br_eqz && result == '0);

	always_comb begin
		if (id2ex.jump_reg) begin
			next_pc = id2ex.reg2_data;
		end else if (taken) begin
			next_pc = id2ex.branch_dest;
		end else begin
			next_pc = id2ex.pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex2wb <= '0;
		end else if (exec_en) begin
			ex2wb.result <= result;
			ex2wb.store_data <= id2ex.reg2_data;
			ex2wb.wb_addr <= id2ex.wb_addr;
			ex2wb.mem_op <= id2ex.mem_op;
			ex2wb.next_pc <= next_pc;
		end
	end

endmodule

//--- source/data_mem.sv
module data_mem (
	input logic clk,
	input logic rst,
	input logic mem_en,
	input mips_pkg::ex2wb_t ex2wb,
	output mips_pkg::word_t load_data
);

	mips_pkg::word_t mem [mips_pkg::dmem_words];
	logic [mips_pkg::dmem_addr_w-1:0] index;

	assign index = ex2wb.result[mips_pkg::dmem_addr_w+1:2]; // word address

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < mips_pkg::dmem_words; i++) begin
				mem[i] <= '0;
			end
		end else if (mem_en) begin
			if (ex2wb.mem_op == mips_pkg::mem_sw) begin
				mem[index] <= ex2wb.store_data;
			end
			if (ex2wb.mem_op == mips_pkg::mem_lw) begin
				load_data <= mem[index];
			end
		end
	end

endmodule

//--- source/fetch_unit.sv
module fetch_unit (
	input logic clk,
	input logic rst,
	input logic fetch_start,
	input logic imem_ack,
	input mips_pkg::instr_t imem_data,
	input logic wb_en,
	input mips_pkg::word_t next_pc,
	output logic fetch_done,
	output logic imem_req,
	output mips_pkg::word_t imem_addr,
	output mips_pkg::instr_t instr,
	output mips_pkg::word_t pc
);

	typedef enum logic [1:0] {f_idle, f_req, f_wait} fetch_state_e;

	fetch_state_e state;

	// req rises with fetch_start, held until ack
	assign imem_req = fetch_start || state == f_req;
	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= f_idle;
			fetch_done <= 1'b0;
			pc <= '0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				f_idle: if (fetch_start) state <= f_req;
				f_req: if (imem_ack) state <= f_wait;
				f_wait: begin
					if (!imem_ack) begin // memory finished phase 4
						fetch_done <= 1'b1;
						state <= f_idle;
					end
				end
				default: state <= f_idle;
			endcase
			if (wb_en) pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (state == f_req && imem_ack) instr <= imem_data;
	end

endmodule

//--- source/core_ctrl.sv
module core_ctrl (
	input logic clk,
	input logic rst,
	input logic fetch_done,
	input mips_pkg::ex2wb_t ex2wb,
	input mips_pkg::word_t load_data,
	input mips_pkg::word_t pc,
	output logic fetch_start,
	output logic decode_en,
	output logic exec_en,
	output logic mem_en,
	output logic wb_en,
	output mips_pkg::reg_addr_t reg_write_addr,
	output mips_pkg::word_t reg_write_data,
	output logic reg_write_en,
	output logic retire_valid,
	output mips_pkg::retire_t retire
);

	mips_pkg::ctrl_state_e state;
	mips_pkg::ctrl_state_e state_next;

	always_comb begin
		case (state)
			mips_pkg::st_idle: state_next = mips_pkg::st_fetch;
			mips_pkg::st_fetch: state_next = fetch_done ? mips_pkg::st_decode : mips_pkg::st_fetch;
			mips_pkg::st_decode: state_next = mips_pkg::st_execute;
			mips_pkg::st_execute: state_next = mips_pkg::st_memory;
			mips_pkg::st_memory: state_next = mips_pkg::st_writeback;
			mips_pkg::st_writeback: state_next = mips_pkg::st_fetch;
			default: state_next = mips_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mips_pkg::st_idle;
			fetch_start <= 1'b0;
		end else begin
			state <= state_next;
			// pulse on entry to fetch only
			fetch_start <= state_next == mips_pkg::st_fetch && state != mips_pkg::st_fetch;
		end
	end

	// remaining stages last one cycle each
	assign decode_en = state == mips_pkg::st_decode;
	assign exec_en = state == mips_pkg::st_execute;
	assign mem_en = state == mips_pkg::st_memory;
	assign wb_en = state == mips_pkg::st_writeback;

	assign reg_write_addr = ex2wb.wb_addr;
	assign reg_write_data = (ex2wb.mem_op == mips_pkg::mem_lw) ? load_data : ex2wb.result;
	assign reg_write_en = wb_en && ex2wb.wb_addr != '0;

	assign retire_valid = wb_en;
	assign retire.pc = pc; // pc not yet advanced in writeback
	assign retire.wb_addr = ex2wb.wb_addr;
	assign retire.wb_data = reg_write_data;

endmodule

//--- source/mips_core.sv
module mips_core (
	input logic clk,
	input logic rst,
	output logic imem_req,
	output mips_pkg::word_t imem_addr,
	input logic imem_ack,
	input mips_pkg::instr_t imem_data,
	output logic retire_valid,
	output mips_pkg::retire_t retire
);

	logic fetch_start;
	logic fetch_done;
	logic decode_en;
	logic exec_en;
	logic mem_en;
	logic wb_en;
	logic reg_write_en;
	mips_pkg::reg_addr_t reg_write_addr;
	mips_pkg::word_t reg_write_data;
	mips_pkg::instr_t instr;
	mips_pkg::word_t pc;
	mips_pkg::word_t load_data;
	mips_pkg::id2ex_t id2ex;
	mips_pkg::ex2wb_t ex2wb;

	fetch_unit fetch_unit_i (
		.clk(clk),
		.rst(rst),
		.fetch_start(fetch_start),
		.imem_ack(imem_ack),
		.imem_data(imem_data),
		.wb_en(wb_en),
		.next_pc(ex2wb.next_pc),
		.fetch_done(fetch_done),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.instr(instr),
		.pc(pc)
	);

	stage_id stage_id_i (
		.clk(clk),
		.rst(rst),
		.decode_en(decode_en),
		.instr(instr),
		.pc(pc),
		.reg_write_addr(reg_write_addr),
		.reg_write_data(reg_write_data),
		.reg_write_en(reg_write_en),
		.id2ex(id2ex)
	);

	alu alu_i (
		.clk(clk),
		.rst(rst),
		.exec_en(exec_en),
		.id2ex(id2ex),
		.ex2wb(ex2wb)
	);

	data_mem data_mem_i (
		.clk(clk),
		.rst(rst),
		.mem_en(mem_en),
		.ex2wb(ex2wb),
		.load_data(load_data)
	);

	core_ctrl core_ctrl_i (
		.clk(clk),
		.rst(rst),
		.fetch_done(fetch_done),
		.ex2wb(ex2wb),
		.load_data(load_data),
		.pc(pc),
		.fetch_start(fetch_start),
		.decode_en(decode_en),
		.exec_en(exec_en),
		.mem_en(mem_en),
		.wb_en(wb_en),
		.reg_write_addr(reg_write_addr),
		.reg_write_data(reg_write_data),
		.reg_write_en(reg_write_en),
		.retire_valid(retire_valid),
		.retire(retire)
	);

endmodule

//--- tb/mips_core_sva.sv
module mips_core_sva (
	input logic clk,
	input logic rst,
	input logic imem_req,
	input mips_pkg::word_t imem_addr,
	input logic imem_ack,
	input logic retire_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	logic addr_fail = 1'b0;
	logic req_fail = 1'b0;
	logic pulse_fail = 1'b0;
	logic gap_fail = 1'b0;
	logic failed;

	assign failed = addr_fail | req_fail | pulse_fail | gap_fail;

	addr_stable: assert property (@(posedge clk) disable iff (rst)
		imem_req && $past(imem_req) |-> $stable(imem_addr))
		else begin
			$error("imem_addr changed while imem_req was high");
			addr_fail = 1'b1;
		end

	// phase 4 must finish before a new request
	req_after_ack: assert property (@(posedge clk) disable iff (rst)
		imem_ack && !imem_req |=> !imem_req)
		else begin
			$error("imem_req rose while imem_ack was still high");
			req_fail = 1'b1;
		end

	retire_pulse: assert property (@(posedge clk) disable iff (rst)
		retire_valid |=> !retire_valid)
		else begin
			$error("retire_valid high for more than one cycle");
			pulse_fail = 1'b1;
		end

	retire_gap: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> !$past(retire_valid, 1) && !$past(retire_valid, 2) &&
			!$past(retire_valid, 3) && !$past(retire_valid, 4))
		else begin
			$error("two retirements within four cycles");
			gap_fail = 1'b1;
		end

endmodule

bind mips_core mips_core_sva mips_core_sva_i (
	.clk(clk),
	.rst(rst),
	.imem_req(imem_req),
	.imem_addr(imem_addr),
	.imem_ack(imem_ack),
	.retire_valid(retire_valid)
);

//--- tb/mips_core_tb.sv
module mips_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rst;
	logic imem_req;
	mips_pkg::word_t imem_addr;
	logic imem_ack;
	mips_pkg::instr_t imem_data;
	logic retire_valid;
	mips_pkg::retire_t retire;

	mips_pkg::instr_t prog [512];
	int prog_len;
	mips_pkg::word_t halt_pc;
	int unsigned ack_delay [1024];
	int unsigned release_delay [1024];

	// instruction-set model state
	mips_pkg::word_t ref_regs [32];
	mips_pkg::word_t ref_mem [256];
	mips_pkg::word_t ref_pc;

	int expect_count;
	int timeout_cycles;
	int cycle_count = 0;
	logic run_done;

	mips_core mips_core_i (
		.clk(clk),
		.rst(rst),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_data(imem_data),
		.retire_valid(retire_valid),
		.retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input mips_pkg::word_t got,
			input mips_pkg::word_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			abort_run("DUT output differs from the instruction-set model");
		end
	endtask

	function automatic mips_pkg::instr_t fetch_word(input mips_pkg::word_t addr);
		return prog[addr[10:2]];
	endfunction

	function automatic mips_pkg::instr_t enc_r(input mips_pkg::funct_t fn,
			input mips_pkg::reg_addr_t rd, input mips_pkg::reg_addr_t rs,
			input mips_pkg::reg_addr_t rt);
		return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mips_pkg::instr_t enc_i(input mips_pkg::opcode_t op,
			input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::instr_t enc_j(input mips_pkg::opcode_t op, input int target);
		return {op, 26'(target)}; // word index inside region 0
	endfunction

	function automatic mips_pkg::instr_t enc_beq(input mips_pkg::reg_addr_t rs,
			input mips_pkg::reg_addr_t rt, input int from, input int dest);
		return {mips_pkg::op_beq, rs, rt, 16'(dest - from - 1)};
	endfunction

	task automatic emit(input mips_pkg::instr_t ins);
		prog[prog_len] = ins;
		prog_len++;
	endtask

	function automatic void ref_reset();
		foreach (ref_regs[i]) ref_regs[i] = '0;
		foreach (ref_mem[i]) ref_mem[i] = '0;
		ref_pc = '0;
	endfunction

	// executes the instruction at ref_pc, returns what should retire
	function automatic mips_pkg::retire_t ref_step();
		mips_pkg::instr_t ins;
		mips_pkg::retire_t r;
		mips_pkg::opcode_t op;
		mips_pkg::reg_addr_t rs;
		mips_pkg::reg_addr_t rt;
		mips_pkg::reg_addr_t dest;
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		mips_pkg::word_t sx;
		mips_pkg::word_t value;
		mips_pkg::word_t addr;
		mips_pkg::word_t npc;
		ins = fetch_word(ref_pc);
		op = ins[31:26];
		rs = ins[25:21];
		rt = ins[20:16];
		a = ref_regs[rs];
		b = ref_regs[rt];
		sx = {{16{ins[15]}}, ins[15:0]};
		dest = '0;
		value = '0;
		npc = ref_pc + 32'd4;
		case (op)
			mips_pkg::op_rtype: begin
				dest = ins[15:11];
				case (ins[5:0])
					mips_pkg::fn_addu: value = a + b;
					mips_pkg::fn_subu: value = a - b;
					mips_pkg::fn_and: value = a & b;
					mips_pkg::fn_or: value = a | b;
					mips_pkg::fn_slt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mips_pkg::fn_jr: begin
						dest = '0;
						npc = a;
					end
					default: dest = '0; // unsupported function acts as no-op
				endcase
			end
			mips_pkg::op_j: npc = {npc[31:28], ins[25:0], 2'b00};
			mips_pkg::op_jal: begin
				dest = 5'd31;
				value = ref_pc + 32'd4;
				npc = {npc[31:28], ins[25:0], 2'b00};
			end
			mips_pkg::op_beq: begin
				value = a - b;
				if (a == b) npc = npc + {sx[29:0], 2'b00};
			end
			mips_pkg::op_addiu: begin
				dest = rt;
				value = a + sx;
			end
			mips_pkg::op_ori: begin
				dest = rt;
				value = a | {16'h0, ins[15:0]};
			end
			mips_pkg::op_lui: begin
				dest = rt;
				value = {ins[15:0], 16'h0};
			end
			mips_pkg::op_lw: begin
				addr = a + sx;
				dest = rt;
				value = ref_mem[addr[9:2]];
			end
			mips_pkg::op_sw: begin
				addr = a + sx;
				value = addr;
				ref_mem[addr[9:2]] = b;
			end
			default: ;
		endcase
		if (dest != '0) ref_regs[dest] = value;
		r.pc = ref_pc;
		r.wb_addr = dest;
		r.wb_data = value;
		ref_pc = npc;
		return r;
	endfunction

	task automatic build_program();
		mips_pkg::reg_addr_t rd;
		mips_pkg::reg_addr_t rs;
		mips_pkg::reg_addr_t rt;
		logic [15:0] imm;
		int unsigned addr;
		int unsigned pick;
		int loop_idx;
		for (int i = 0; i < 512; i++) begin
			prog[i] = {6'h3f, 26'(i)}; // unused words decode as invalid
		end
		prog_len = 0;
		for (int r = 1; r < 16; r++) begin
			emit(enc_i(mips_pkg::op_lui, 5'(r), 5'd0, 16'($urandom)));
			emit(enc_i(mips_pkg::op_ori, 5'(r), 5'(r), 16'($urandom)));
		end
		// random alu mix, r0 as destination now and then
		for (int n = 0; n < 48; n++) begin
			rd = 5'($urandom_range(15, 0));
			rs = 5'($urandom_range(15, 0));
			rt = 5'($urandom_range(15, 0));
			imm = 16'($urandom);
			pick = $urandom_range(7, 0);
			case (pick)
				0: emit(enc_r(mips_pkg::fn_addu, rd, rs, rt));
				1: emit(enc_r(mips_pkg::fn_subu, rd, rs, rt));
				2: emit(enc_r(mips_pkg::fn_and, rd, rs, rt));
				3: emit(enc_r(mips_pkg::fn_or, rd, rs, rt));
				4: emit(enc_r(mips_pkg::fn_slt, rd, rs, rt));
				5: emit(enc_i(mips_pkg::op_addiu, rd, rs, imm));
				6: emit(enc_i(mips_pkg::op_ori, rd, rs, imm));
				default: emit(enc_i(mips_pkg::op_lui, rd, rs, imm));
			endcase
		end
		emit(enc_r(mips_pkg::fn_addu, 5'd0, 5'd1, 5'd2));
		emit(enc_i(mips_pkg::op_addiu, 5'd0, 5'd3, 16'h7fff));
		emit(enc_r(mips_pkg::fn_or, 5'd4, 5'd0, 5'd0)); // r0 must read back zero
		// store then reload through a shifted base
		for (int n = 0; n < 12; n++) begin
			addr = $urandom_range(255, 0);
			emit(enc_i(mips_pkg::op_addiu, 5'd16, 5'd0, 16'(addr * 4)));
			emit(enc_i(mips_pkg::op_lui, 5'd17, 5'd0, 16'($urandom)));
			emit(enc_i(mips_pkg::op_ori, 5'd17, 5'd17, 16'($urandom)));
			emit(enc_i(mips_pkg::op_sw, 5'd17, 5'd16, 16'd0));
			emit(enc_i(mips_pkg::op_addiu, 5'd18, 5'd0, 16'(addr * 4 + 8)));
			emit(enc_i(mips_pkg::op_lw, 5'd19, 5'd18, 16'hfff8));
		end
		for (int n = 0; n < 8; n++) begin
			addr = $urandom_range(255, 0); // mostly never written
			emit(enc_i(mips_pkg::op_addiu, 5'd20, 5'd0, 16'(addr * 4)));
			emit(enc_i(mips_pkg::op_lw, 5'd21, 5'd20, 16'd0));
		end
		// counted loop, forward exit and backward repeat
		emit(enc_i(mips_pkg::op_addiu, 5'd8, 5'd0, 16'd5));
		emit(enc_i(mips_pkg::op_addiu, 5'd9, 5'd0, 16'd0));
		loop_idx = prog_len;
		emit(enc_i(mips_pkg::op_addiu, 5'd9, 5'd9, 16'd3));
		emit(enc_i(mips_pkg::op_addiu, 5'd8, 5'd8, 16'hffff));
		emit(enc_beq(5'd8, 5'd0, prog_len, prog_len + 2));
		emit(enc_beq(5'd0, 5'd0, prog_len, loop_idx));
		emit(enc_beq(5'd9, 5'd8, prog_len, prog_len + 2)); // not taken
		emit(enc_i(mips_pkg::op_addiu, 5'd10, 5'd0, 16'd7));
		emit(enc_beq(5'd10, 5'd10, prog_len, prog_len + 2)); // taken, skips one
		emit(enc_i(mips_pkg::op_addiu, 5'd10, 5'd0, 16'd99));
		// call and return
		emit(enc_j(mips_pkg::op_jal, prog_len + 3));
		emit(enc_i(mips_pkg::op_addiu, 5'd11, 5'd31, 16'd0));
		emit(enc_j(mips_pkg::op_j, prog_len + 3));
		emit(enc_i(mips_pkg::op_addiu, 5'd12, 5'd0, 16'h0055));
		emit(enc_r(mips_pkg::fn_jr, 5'd0, 5'd31, 5'd0));
		emit({6'h3f, 26'h2a5a5a5});
		emit({6'h01, 5'd1, 5'd2, 16'h1234});
		emit(enc_r(6'h00, 5'd5, 5'd1, 5'd2)); // function 0 not supported
		for (int r = 1; r < 32; r++) begin
			emit(enc_r(mips_pkg::fn_or, 5'(r), 5'(r), 5'd0)); // read back every register
		end
		halt_pc = mips_pkg::word_t'(prog_len * 4);
		emit(enc_j(mips_pkg::op_j, prog_len));
	endtask

	// instruction memory, random ack delay per fetch
	initial begin : imem_responder
		int unsigned fetch_count;
		int unsigned idx;
		mips_pkg::word_t addr;
		imem_ack = 1'b0;
		imem_data = '0;
		fetch_count = 0;
		forever begin
			@(posedge clk);
			#1;
			if (imem_req && !imem_ack) begin
				addr = imem_addr;
				if (addr[31:11] != '0 || addr[1:0] != 2'b00) begin
					abort_run($sformatf("fetch from address %h outside the program", addr));
				end
				check_value("imem_addr", addr, ref_pc);
				idx = fetch_count % 1024;
				repeat (ack_delay[idx]) begin
					@(posedge clk);
					#1;
				end
				fetch_count++;
				imem_data = fetch_word(addr);
				imem_ack = 1'b1;
				do begin
					@(posedge clk);
					#1;
				end while (imem_req);
				repeat (release_delay[idx]) begin // ack held past the fall of req
					@(posedge clk);
					#1;
				end
				imem_ack = 1'b0;
			end
		end
	end

	initial begin : retire_checker
		mips_pkg::retire_t exp;
		run_done = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (retire_valid && !rst) begin
				exp = ref_step();
				check_value("retire.pc", retire.pc, exp.pc);
				check_value("retire.wb_addr", mips_pkg::word_t'(retire.wb_addr),
					mips_pkg::word_t'(exp.wb_addr));
				check_value("retire.wb_data", retire.wb_data, exp.wb_data);
				if (exp.pc == halt_pc) run_done = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (!rst) begin
			cycle_count++;
			if (cycle_count > timeout_cycles) begin
				abort_run("timed out before the program reached its halt loop");
			end
			if (mips_core_i.mips_core_sva_i.failed) begin
				abort_run("an assertion on the fetch port or the retire port failed");
			end
		end
	end

	initial begin : main
		mips_pkg::retire_t r;
		rst = 1'b1;
		void'($urandom(31705));
		for (int i = 0; i < 1024; i++) begin
			ack_delay[i] = $urandom_range(3, 0);
			release_delay[i] = $urandom_range(1, 0);
		end
		build_program();
		// dry run of the model to size the timeout
		ref_reset();
		expect_count = 0;
		do begin
			r = ref_step();
			expect_count++;
		end while (r.pc != halt_pc && expect_count < 4096);
		if (r.pc != halt_pc) abort_run("program never reaches its halt loop");
		ref_reset();
		timeout_cycles = expect_count * 12 + 100; // up to 8 fetch + 4 stages
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		wait (run_done);
		repeat (4) @(posedge clk);
		if (mips_core_i.mips_core_sva_i.failed) begin
			abort_run("an assertion on the fetch port or the retire port failed");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

//--- tb.f
source/mips_pkg.sv
source/register_file.sv
source/stage_id.sv
source/alu.sv
source/data_mem.sv
source/fetch_unit.sv
source/core_ctrl.sv
source/mips_core.sv
tb/mips_core_sva.sv
tb/mips_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mips_core_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f tb.f
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
